//--- cdb_settings.svh
`ifndef CDB_SETTINGS_SVH
`define CDB_SETTINGS_SVH

// Operand, result and address width
`define CDB_DATA_W 32

// Reorder-buffer tag width
`define CDB_TAG_W 3

// Entry count, kept at 2**CDB_TAG_W so tags wrap cleanly
`define CDB_ROB_DEPTH 8

`endif

//--- cdbPkg.sv
`include "cdb_settings.svh"

package cdbPkg;

  typedef logic [`CDB_DATA_W-1:0] dataT;  // Data word
  typedef logic [`CDB_TAG_W-1:0] tagT;    // Reorder-buffer tag

  // ALU operation codes
  typedef logic [2:0] aluOpT;
  localparam aluOpT opAdd = 3'd0;
  localparam aluOpT opSub = 3'd1;
  localparam aluOpT opAnd = 3'd2;
  localparam aluOpT opOr  = 3'd3;
  localparam aluOpT opXor = 3'd4;
  localparam aluOpT opSll = 3'd5;  // Shift by b[4:0]
  localparam aluOpT opSrl = 3'd6;
  localparam aluOpT opSlt = 3'd7;  // Signed compare

  // Branch conditions, signed for lt and ge
  typedef logic [1:0] branchOpT;
  localparam branchOpT brEq = 2'd0;
  localparam branchOpT brNe = 2'd1;
  localparam branchOpT brLt = 2'd2;
  localparam branchOpT brGe = 2'd3;

endpackage

//--- fuPort.sv
`timescale 1ns/1ps

// Link between one functional unit and the bus arbiter
interface fuPort;
  import cdbPkg::*;

  logic request;    // Unit holds a finished result
  tagT  tag;
  dataT result;
  dataT target;
  logic isControl;
  logic grant;      // Bus takes the result at the next edge

  // Payload stays stable while request is high and grant is low
  modport unit (
    output request, tag, result, target, isControl,
    input  grant
  );

  modport arbiter (
    input  request, tag, result, target, isControl,
    output grant
  );

endinterface

//--- commonDataBus.sv
`timescale 1ns/1ps

// Registered result broadcast, one cycle per grant
interface commonDataBus;
  import cdbPkg::*;

  logic validBroadcast;  // Bus holds a live result this cycle
  tagT  robEntry;        // Destination entry in the reorder buffer
  dataT result;
  dataT targetAddress;   // Branch target, zero from the ALU
  logic isControl;       // Taken branch, redirect at retirement

  // Arbiter owns every field
  modport arbiter (
    output validBroadcast, robEntry, result, targetAddress, isControl
  );

  // Reorder buffer only listens
  modport reorderBuffer (
    input validBroadcast, robEntry, result, targetAddress, isControl
  );

endinterface

//--- aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
  input  logic          clk,
  input  logic          rstN,
  input  logic          issue,
  input  cdbPkg::aluOpT op,
  input  cdbPkg::dataT  a,
  input  cdbPkg::dataT  b,
  input  cdbPkg::tagT   tag,
  output logic          busy,
  fuPort.unit           fu
);
  import cdbPkg::*;

  dataT aluOut;     // Combinational result of the issued op
  dataT resultQ;    // Holding register payload
  tagT  tagQ;
  logic validQ;     // Holding register occupied
  logic accept;

  assign accept = issue && !validQ;  // Issue while busy is dropped

  always_comb begin
    case (op)
      opAdd:   aluOut = a + b;
      opSub:   aluOut = a - b;
      opAnd:   aluOut = a & b;
      opOr:    aluOut = a | b;
      opXor:   aluOut = a ^ b;
      opSll:   aluOut = a << b[4:0];
      opSrl:   aluOut = a >> b[4:0];
      default: aluOut = dataT'($signed(a) < $signed(b));  // Slt gives 0 or 1
    endcase
  end

  // Occupancy, cleared at the edge after the grant
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else if (validQ && fu.grant) begin
      validQ <= 1'b0;
    end else if (accept) begin
      validQ <= 1'b1;
    end
  end

  // Payload, loaded only on an accepted issue
  always_ff @(posedge clk) begin
    if (accept) begin
      resultQ <= aluOut;
      tagQ    <= tag;
    end
  end

  assign busy         = validQ;
  assign fu.request   = validQ;
  assign fu.tag       = tagQ;
  assign fu.result    = resultQ;
  assign fu.target    = '0;      // No target from the ALU
  assign fu.isControl = 1'b0;

endmodule

//--- branchUnit.sv
`timescale 1ns/1ps

module branchUnit (
  input  logic             clk,
  input  logic             rstN,
  input  logic             issue,
  input  cdbPkg::branchOpT op,
  input  cdbPkg::dataT     a,
  input  cdbPkg::dataT     b,
  input  cdbPkg::dataT     pc,
  input  cdbPkg::dataT     offset,
  input  cdbPkg::tagT      tag,
  output logic             busy,
  fuPort.unit              fu
);
  import cdbPkg::*;

  logic taken;      // Condition outcome
  dataT linkQ;      // pc + 4
  dataT targetQ;    // pc + offset
  logic takenQ;
  tagT  tagQ;
  logic validQ;
  logic accept;

  assign accept = issue && !validQ;

  // Condition evaluation
  always_comb begin
    case (op)
      brEq:    taken = (a == b);
      brNe:    taken = (a != b);
      brLt:    taken = ($signed(a) < $signed(b));
      default: taken = ($signed(a) >= $signed(b));  // Bge
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else if (validQ && fu.grant) begin
      validQ <= 1'b0;                // Bus took the entry
    end else if (accept) begin
      validQ <= 1'b1;
    end
  end

  // Link value, target and outcome held until broadcast
  always_ff @(posedge clk) begin
    if (accept) begin
      linkQ   <= pc + dataT'(4);
      targetQ <= pc + offset;
      takenQ  <= taken;
      tagQ    <= tag;
    end
  end

  assign busy         = validQ;
  assign fu.request   = validQ;
  assign fu.tag       = tagQ;
  assign fu.result    = linkQ;
  assign fu.target    = targetQ;
  assign fu.isControl = takenQ;   // Redirect only when taken

endmodule

//--- cdbArbiter.sv
`timescale 1ns/1ps

module cdbArbiter (
  input  logic          clk,
  input  logic          rstN,
  fuPort.arbiter        alu,
  fuPort.arbiter        branch,
  commonDataBus.arbiter bus
);
  import cdbPkg::*;

  logic pointer;    // 0 favours the ALU, 1 favours the branch unit
  logic grantAlu;
  logic grantBr;
  tagT  winTag;
  dataT winResult;
  dataT winTarget;
  logic winControl;

  // Lone requester always wins, a tie goes to the pointer
  assign grantAlu = alu.request && (!branch.request || !pointer);
  assign grantBr  = branch.request && (!alu.request || pointer);

  assign alu.grant    = grantAlu;
  assign branch.grant = grantBr;

  // Winner's payload mux
  always_comb begin
    if (grantBr) begin
      winTag     = branch.tag;
      winResult  = branch.result;
      winTarget  = branch.target;
      winControl = branch.isControl;
    end else begin
      winTag     = alu.tag;
      winResult  = alu.result;
      winTarget  = alu.target;
      winControl = alu.isControl;
    end
  end

  // Priority moves to the other unit after every grant
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pointer <= 1'b0;
    end else if (grantAlu) begin
      pointer <= 1'b1;
    end else if (grantBr) begin
      pointer <= 1'b0;
    end
  end

  // Broadcast strobe, low after any idle cycle
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      bus.validBroadcast <= 1'b0;
    end else begin
      bus.validBroadcast <= grantAlu || grantBr;
    end
  end

  always_ff @(posedge clk) begin
    if (grantAlu || grantBr) begin
      bus.robEntry      <= winTag;
      bus.result        <= winResult;
      bus.targetAddress <= winTarget;
      bus.isControl     <= winControl;
    end
  end

endmodule

//--- reorderBuffer.sv
`timescale 1ns/1ps

`include "cdb_settings.svh"

module reorderBuffer (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 allocReq,
  output logic                 allocReady,
  output cdbPkg::tagT          allocTag,
  commonDataBus.reorderBuffer  bus,
  output logic                 retireValid,
  output cdbPkg::tagT          retireTag,
  output cdbPkg::dataT         retireResult,
  output logic                 retireRedirect,
  output cdbPkg::dataT         retireTarget
);
  import cdbPkg::*;

  tagT  head;                          // Oldest entry
  tagT  tail;                          // Next tag to hand out
  logic [`CDB_TAG_W:0] count;          // Occupancy, one bit wider than a tag
  logic doAlloc;
  logic doRetire;

  logic doneQ      [`CDB_ROB_DEPTH];   // Result captured from the bus
  dataT resultMem  [`CDB_ROB_DEPTH];
  logic redirectMem[`CDB_ROB_DEPTH];
  dataT targetMem  [`CDB_ROB_DEPTH];

  assign allocReady = (count != (`CDB_TAG_W+1)'(`CDB_ROB_DEPTH));
  assign allocTag   = tail;
  assign doAlloc    = allocReq && allocReady;  // Request while full is ignored

  // Retire straight from the head entry
  assign retireValid    = (count != '0) && doneQ[head];
  assign retireTag      = head;
  assign retireResult   = resultMem[head];
  assign retireRedirect = redirectMem[head];
  assign retireTarget   = targetMem[head];
  assign doRetire       = retireValid;  // No back-pressure

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (doAlloc) begin
        tail <= tail + 1'b1;            // Wraps with the tag width
      end
      if (doRetire) begin
        head <= head + 1'b1;
      end
      case ({doAlloc, doRetire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Both or neither
      endcase
    end
  end

  // Done flags, set by a broadcast and cleared on allocation
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `CDB_ROB_DEPTH; i++) begin
        doneQ[i] <= 1'b0;
      end
    end else begin
      if (bus.validBroadcast) begin
        doneQ[bus.robEntry] <= 1'b1;
      end
      if (doAlloc) begin
        doneQ[tail] <= 1'b0;            // Fresh entry starts pending
      end
    end
  end

  // Completion payload captured from the bus
  always_ff @(posedge clk) begin
    if (bus.validBroadcast) begin
      resultMem[bus.robEntry]   <= bus.result;
      redirectMem[bus.robEntry] <= bus.isControl;
      targetMem[bus.robEntry]   <= bus.targetAddress;
    end
  end

endmodule

//--- cdbCore.sv
`timescale 1ns/1ps

module cdbCore (
  input  logic             clk,
  input  logic             rstN,
  // Tag allocation
  input  logic             allocReq,
  output logic             allocReady,
  output cdbPkg::tagT      allocTag,
  // ALU issue
  input  logic             aluIssue,
  input  cdbPkg::aluOpT    aluOp,
  input  cdbPkg::dataT     aluA,
  input  cdbPkg::dataT     aluB,
  input  cdbPkg::tagT      aluTag,
  output logic             aluBusy,
  // Branch issue
  input  logic             brIssue,
  input  cdbPkg::branchOpT brOp,
  input  cdbPkg::dataT     brA,
  input  cdbPkg::dataT     brB,
  input  cdbPkg::dataT     brPc,
  input  cdbPkg::dataT     brOffset,
  input  cdbPkg::tagT      brTag,
  output logic             brBusy,
  // Broadcast view
  output logic             cdbValid,
  output cdbPkg::tagT      cdbTag,
  output cdbPkg::dataT     cdbResult,
  // In-order retirement
  output logic             retireValid,
  output cdbPkg::tagT      retireTag,
  output cdbPkg::dataT     retireResult,
  output logic             retireRedirect,
  output cdbPkg::dataT     retireTarget
);

  fuPort        aluPort ();
  fuPort        brPort ();
  commonDataBus cdb ();

  aluUnit alu0 (
    .clk  (clk),
    .rstN (rstN),
    .issue(aluIssue),
    .op   (aluOp),
    .a    (aluA),
    .b    (aluB),
    .tag  (aluTag),
    .busy (aluBusy),
    .fu   (aluPort.unit)
  );

  branchUnit br0 (
    .clk   (clk),
    .rstN  (rstN),
    .issue (brIssue),
    .op    (brOp),
    .a     (brA),
    .b     (brB),
    .pc    (brPc),
    .offset(brOffset),
    .tag   (brTag),
    .busy  (brBusy),
    .fu    (brPort.unit)
  );

  // Grants one unit per cycle and registers it onto the bus
  cdbArbiter arb0 (
    .clk   (clk),
    .rstN  (rstN),
    .alu   (aluPort.arbiter),
    .branch(brPort.arbiter),
    .bus   (cdb.arbiter)
  );

  reorderBuffer rob0 (
    .clk           (clk),
    .rstN          (rstN),
    .allocReq      (allocReq),
    .allocReady    (allocReady),
    .allocTag      (allocTag),
    .bus           (cdb.reorderBuffer),
    .retireValid   (retireValid),
    .retireTag     (retireTag),
    .retireResult  (retireResult),
    .retireRedirect(retireRedirect),
    .retireTarget  (retireTarget)
  );

  assign cdbValid  = cdb.validBroadcast;  // Bus fields exposed for observation
  assign cdbTag    = cdb.robEntry;
  assign cdbResult = cdb.result;

endmodule

//--- cdbCore_properties.sv
`timescale 1ns/1ps

// Arbiter and bus rules, bound into every cdbArbiter
module cdbCoreProperties (
  input logic clk,
  input logic rstN,
  input logic aluReq,
  input logic brReq,
  input logic aluGrant,
  input logic brGrant,
  input logic busValid
);

  grantsExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(aluGrant && brGrant)) else $error("Both units granted in one cycle");

  // A grant never appears without its request
  grantNeedsRequest: assert property (@(posedge clk) disable iff (!rstN)
    !(aluGrant && !aluReq) && !(brGrant && !brReq)) else $error("Grant without request");

  aluRequestHeld: assert property (@(posedge clk) disable iff (!rstN)
    aluReq && !aluGrant |=> aluReq) else $error("ALU request dropped before grant");

  brRequestHeld: assert property (@(posedge clk) disable iff (!rstN)
    brReq && !brGrant |=> brReq) else $error("Branch request dropped before grant");

  // Broadcast strobe is the grant delayed by one edge
  broadcastFollowsGrant: assert property (@(posedge clk) disable iff (!rstN)
    aluGrant || brGrant |=> busValid) else $error("Grant without broadcast");

  noBroadcastWithoutGrant: assert property (@(posedge clk) disable iff (!rstN)
    !(aluGrant || brGrant) |=> !busValid) else $error("Broadcast without grant");

endmodule

bind cdbArbiter cdbCoreProperties props0 (
  .clk(clk), .rstN(rstN), .aluReq(alu.request), .brReq(branch.request),
  .aluGrant(grantAlu), .brGrant(grantBr), .busValid(bus.validBroadcast)
);

//--- cdbCoreTb.sv
`timescale 1ns/1ps

`include "cdb_settings.svh"

module cdbCoreTb;
  import cdbPkg::*;

  logic clk, rstN, allocReq, allocReady, aluIssue, aluBusy, brIssue, brBusy;
  logic cdbValid, retireValid, retireRedirect;
  tagT allocTag, aluTag, brTag, cdbTag, retireTag;
  aluOpT aluOp;
  branchOpT brOp;
  dataT aluA, aluB, brA, brB, brPc, brOffset, cdbResult, retireResult, retireTarget;

  logic [31:0] randState = 32'd55414;
  int checks, errors, markChecks, markErrors, bcastSeen;
  bit timedOut;
  // Reference model state, post-edge view
  bit mAluOcc, mBrOcc, mPtr, mCdbValid;
  tagT mAluTag, mBrTag, mCdbTag, mHead, mTail;
  int mCount;
  bit mDone[`CDB_ROB_DEPTH];
  dataT expRes[`CDB_ROB_DEPTH];
  bit expRedir[`CDB_ROB_DEPTH];
  dataT expTgt[`CDB_ROB_DEPTH];
  tagT allocOrder[$];   // Allocated, not yet retired
  tagT pending[$];      // Allocated, not yet issued

  cdbCore dut0 (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] lcgNext();
    randState = randState * 32'd1103515245 + 32'd12345;
    return randState;
  endfunction

  function automatic dataT aluRef(input logic [2:0] op, input dataT a, input dataT b);
    case (op)
      3'd0: return a + b;
      3'd1: return a - b;
      3'd2: return a & b;
      3'd3: return a | b;
      3'd4: return a ^ b;
      3'd5: return a << b[4:0];
      3'd6: return a >> b[4:0];
      default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
  endfunction

  function automatic bit branchTaken(input logic [1:0] op, input dataT a, input dataT b);
    case (op)
      2'd0: return a == b;
      2'd1: return a != b;
      2'd2: return $signed(a) < $signed(b);
      default: return $signed(a) >= $signed(b);
    endcase
  endfunction

  task automatic expectEq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Compare every DUT output with the model, called at the falling edge
  task automatic checkOutputs();
    bit rv;
    rv = (mCount != 0) && mDone[mHead];
    if (cdbValid === 1'b1) bcastSeen++;
    expectEq(aluBusy, mAluOcc, "aluBusy");
    expectEq(brBusy, mBrOcc, "brBusy");
    expectEq(cdbValid, mCdbValid, "cdbValid");
    if (mCdbValid) begin
      expectEq(cdbTag, mCdbTag, "cdbTag");
      expectEq(cdbResult, expRes[mCdbTag], "cdbResult");
    end
    expectEq(allocReady, mCount < `CDB_ROB_DEPTH, "allocReady");
    expectEq(allocTag, mTail, "allocTag");
    expectEq(retireValid, rv, "retireValid");
    if (rv) begin   // Oldest allocation must leave first
      expectEq(retireTag, allocOrder[0], "retireTag");
      expectEq(retireResult, expRes[allocOrder[0]], "retireResult");
      expectEq(retireRedirect, expRedir[allocOrder[0]], "retireRedirect");
      expectEq(retireTarget, expTgt[allocOrder[0]], "retireTarget");
    end
  endtask

  // One clock: check, drive at the falling edge, step the model across the rising edge
  task automatic runCycle(input bit wantAlloc, input bit wantAlu, input bit wantBr,
                          input int aluOpSel, input int brOpSel);
    bit gA, gB, rv, doAlloc, aluAcc, brAcc;
    int idx;
    logic [31:0] r;
    if (timedOut) return;
    checkOutputs();
    allocReq = wantAlloc;
    aluIssue = 0;
    brIssue  = 0;
    idx = 0;
    aluAcc = 0;
    brAcc = 0;
    if (wantAlu && pending.size() > idx) begin
      r = lcgNext();
      aluIssue = 1;
      aluTag = pending[idx];
      aluOp = (aluOpSel < 0) ? aluOpT'(r[18:16]) : aluOpT'(aluOpSel);
      aluA = lcgNext();
      aluB = r[0] ? dataT'(r[28:24]) : lcgNext();  // Small values give useful shifts
      aluAcc = !mAluOcc;   // Busy unit drops the issue
      if (aluAcc) begin
        idx++;
        expRes[aluTag] = aluRef(aluOp, aluA, aluB);
        expRedir[aluTag] = 0;
        expTgt[aluTag] = '0;
      end
    end
    if (wantBr && pending.size() > idx) begin
      r = lcgNext();
      brIssue = 1;
      brTag = pending[idx];
      brOp = (brOpSel < 0) ? branchOpT'(r[17:16]) : branchOpT'(brOpSel);
      brA = lcgNext();
      brB = r[1] ? brA : (r[2] ? -brA : lcgNext());  // Equal operands now and then
      brPc = lcgNext();
      brPc[1:0] = 2'b00;  // Word-aligned pc
      brOffset = {{18{r[13]}}, r[13:2], 2'b00};
      brAcc = !mBrOcc;
      if (brAcc) begin
        idx++;
        expRes[brTag] = brPc + 32'd4;
        expRedir[brTag] = branchTaken(brOp, brA, brB);
        expTgt[brTag] = brPc + brOffset;
      end
    end
    // Model of the next rising edge, all from pre-edge state
    gA = mAluOcc && (!mBrOcc || !mPtr);
    gB = mBrOcc && (!mAluOcc || mPtr);
    rv = (mCount != 0) && mDone[mHead];
    doAlloc = wantAlloc && (mCount < `CDB_ROB_DEPTH);
    if (mCdbValid) mDone[mCdbTag] = 1;
    if (doAlloc) mDone[mTail] = 0;
    if (rv) begin
      void'(allocOrder.pop_front());
      mHead = mHead + 1'b1;
    end
    repeat (idx) void'(pending.pop_front());
    if (doAlloc) begin
      allocOrder.push_back(mTail);
      pending.push_back(mTail);
      mTail = mTail + 1'b1;
    end
    mCount = mCount + int'(doAlloc) - int'(rv);
    mCdbValid = gA || gB;
    mCdbTag = gB ? mBrTag : mAluTag;
    if (gA) mPtr = 1;
    else if (gB) mPtr = 0;
    if (gA) mAluOcc = 0;
    else if (aluAcc) begin
      mAluOcc = 1;
      mAluTag = aluTag;
    end
    if (gB) mBrOcc = 0;
    else if (brAcc) begin
      mBrOcc = 1;
      mBrTag = brTag;
    end
    @(posedge clk);
    @(negedge clk);
  endtask

  // Keep issuing until every entry has retired
  task automatic drain();
    int n;
    n = 0;
    while (!timedOut && (mCount != 0 || mAluOcc || mBrOcc || mCdbValid) && n < 200) begin
      runCycle(0, 1, 1, -1, -1);
      n++;
    end
    if (n >= 200) begin
      $display("Timeout: pipeline did not drain within 200 cycles at %0t", $time);
      errors++;
      timedOut = 1;
    end
  endtask

  task automatic finishTest(input string name);
    $display("Test %s done: %0d checks, %0d errors", name, checks - markChecks,
             errors - markErrors);
    markChecks = checks;
    markErrors = errors;
  endtask

  initial begin
    int edges, startSeen;
    tagT firstTag, secondTag;
    bit tiePtr;
    clk = 0;
    rstN = 0;
    {allocReq, aluIssue, brIssue} = '0;
    {aluTag, brTag, aluOp, brOp} = '0;
    {aluA, aluB, brA, brB, brPc, brOffset} = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstN = 1;

    // Ties, ALU first from reset, then alternating via a lone ALU op
    for (int i = 0; i < 4; i++) begin
      if (i % 2 == 1) begin
        runCycle(1, 0, 0, -1, -1);
        runCycle(0, 1, 0, -1, -1);
        drain();
      end
      runCycle(1, 0, 0, -1, -1);
      runCycle(1, 0, 0, -1, -1);
      firstTag = pending[0];
      secondTag = pending[1];
      tiePtr = mPtr;  // Model pointer decides the tie
      runCycle(0, 1, 1, -1, -1);
      runCycle(0, 0, 0, -1, -1);
      expectEq(cdbTag, tiePtr ? secondTag : firstTag, "tie winner");
      drain();
    end
    finishTest("tieOrder");

    // Every ALU op, uncontended latency of two edges
    for (int op = 0; op < 8; op++) begin
      runCycle(1, 0, 0, -1, -1);
      runCycle(0, 1, 0, op, -1);
      edges = 1;
      while (!timedOut && cdbValid !== 1'b1 && edges < 8) begin
        runCycle(0, 0, 0, -1, -1);
        edges++;
      end
      if (edges >= 8) begin
        $display("Timeout: no ALU broadcast within 8 cycles at %0t", $time);
        errors++;
      end
      expectEq(edges, 2, "ALU broadcast latency");
      drain();
    end
    finishTest("aluOps");

    for (int i = 0; i < 8; i++) begin
      runCycle(1, 0, 0, -1, -1);
      runCycle(0, 0, 1, -1, i % 4);
      drain();
    end
    finishTest("branches");

    // Second issue lands while the ALU is busy
    startSeen = bcastSeen;
    runCycle(1, 0, 0, -1, -1);
    runCycle(1, 0, 0, -1, -1);
    runCycle(0, 1, 0, -1, -1);
    runCycle(0, 1, 0, -1, -1);
    drain();
    expectEq(bcastSeen - startSeen, 2, "broadcast count");
    finishTest("busyIssue");

    repeat (`CDB_ROB_DEPTH) runCycle(1, 0, 0, -1, -1);
    expectEq(allocReady, 0, "allocReady when full");
    firstTag = mTail;  // Tail the model holds while full
    runCycle(1, 0, 0, -1, -1);
    expectEq(allocTag, firstTag, "allocTag after refused allocReq");
    drain();
    finishTest("fullBuffer");

    // Random mix, out-of-order completion comes from the unit mix
    for (int i = 0; i < 300; i++) begin
      edges = lcgNext();
      runCycle(edges[9:8] != 2'b00, edges[12], edges[13], -1, -1);
    end
    drain();
    finishTest("randomMix");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- cdbCore.f
+incdir+.
cdbPkg.sv
fuPort.sv
commonDataBus.sv
aluUnit.sv
branchUnit.sv
cdbArbiter.sv
reorderBuffer.sv
cdbCore.sv
cdbCore_properties.sv
cdbCoreTb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := cdbCoreTb
FILELIST := cdbCore.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
